//--- rtl/snow_cache_pkg.sv
package snow_cache_pkg;

  //--------------------------------------------------
  // virtual address split
  //--------------------------------------------------
  localparam int VADDR_W     = 24;  // virtual word address
  localparam int OFFSET_W    = 10;  // page offset
  localparam int VPN_W       = 14;  // virtual page number
  localparam int TLB_IDX_W   = 4;   // low vpn bits
  localparam int TLB_TAG_W   = 10;  // upper vpn bits
  localparam int TLB_ENTRIES = 1 << TLB_IDX_W;
  localparam int PPN_W       = 4;   // physical page number

  //--------------------------------------------------
  // cache geometry, one word per line
  //--------------------------------------------------
  localparam int CACHE_IDX_W = 8;   // offset bits [7:0]
  localparam int CACHE_TAG_W = 6;   // physical bits [13:8]
  localparam int CACHE_LINES = 1 << CACHE_IDX_W;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_TLB_WRITE
  } cpu_op_t;

  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,   // translate and compare
    C_BUS_REQ,
    C_BUS_WAIT,
    C_RESPOND   // cpu_rsp_valid cycle
  } cache_state_t;

endpackage

//--- rtl/snow_bus_pkg.sv
package snow_bus_pkg;

  localparam int PADDR_W     = 14;     // physical word address
  localparam int DATA_W      = 32;
  localparam int MEM_WORDS   = 16384;
  localparam int MEM_LATENCY = 2;      // accept to response, cycles
  localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);
  localparam int DMA_LEN_W   = 8;      // zero means 256 words

  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  typedef enum logic [2:0] {
    D_IDLE,
    D_READ,
    D_READ_WAIT,
    D_WRITE,
    D_WRITE_WAIT
  } dma_state_t;

endpackage

//--- rtl/snowball_cache.sv
`timescale 1ns/100ps

module snowball_cache
  import snow_cache_pkg::*;
  import snow_bus_pkg::*;
(
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               vmem_on,
  // cpu port
  input  logic               cpu_req_valid,
  output logic               cpu_req_ready,
  input  cpu_op_t            cpu_req_op,
  input  logic [VADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0]  cpu_wdata,
  output logic               cpu_rsp_valid,
  output logic [DATA_W-1:0]  cpu_rsp_data,
  output logic               cpu_rsp_fault,
  // bus master port
  output logic               m0_req_valid,
  input  logic               m0_req_ready,
  output bus_op_t            m0_req_op,
  output logic [PADDR_W-1:0] m0_req_addr,
  output logic [DATA_W-1:0]  m0_req_wdata,
  input  logic               m0_rsp_valid,
  input  logic [DATA_W-1:0]  m0_rsp_rdata,
  // dma write snoop
  input  logic               snoop_valid,
  input  logic [PADDR_W-1:0] snoop_addr
);

  cache_state_t state;

  // tlb, 16 entries in flops
  logic [TLB_TAG_W-1:0]   tlb_tag [TLB_ENTRIES];
  logic [PPN_W-1:0]       tlb_ppn [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] tlb_valid;

  // tag and data arrays
  logic [CACHE_TAG_W-1:0] tag_mem  [CACHE_LINES];
  logic [DATA_W-1:0]      data_mem [CACHE_LINES];
  logic [CACHE_LINES-1:0] line_valid;

  // registered request
  cpu_op_t                req_op_q;
  logic [VADDR_W-1:0]     addr_q;
  logic [DATA_W-1:0]      wdata_q;
  logic [PADDR_W-1:0]     paddr_q;
  logic [DATA_W-1:0]      rsp_data_q;
  logic                   rsp_fault_q;

  logic                   accept;
  logic [VPN_W-1:0]       vpn;
  logic [TLB_IDX_W-1:0]   tlb_idx;
  logic [TLB_TAG_W-1:0]   vtag;
  logic [PPN_W-1:0]       ppn;
  logic                   fault;
  logic [PADDR_W-1:0]     paddr;
  logic [CACHE_IDX_W-1:0] line_idx;
  logic [CACHE_TAG_W-1:0] line_tag;
  logic                   hit;
  logic [CACHE_IDX_W-1:0] fill_idx;
  logic [CACHE_TAG_W-1:0] fill_tag;
  logic [CACHE_IDX_W-1:0] snoop_idx;
  logic [CACHE_TAG_W-1:0] snoop_tag;
  logic                   fill_done;

  assign cpu_req_ready = (state == C_IDLE);
  assign accept        = cpu_req_valid && cpu_req_ready;
  assign cpu_rsp_valid = (state == C_RESPOND);
  assign cpu_rsp_data  = rsp_data_q;
  assign cpu_rsp_fault = rsp_fault_q;

  //--------------------------------------------------
  // translation and lookup, valid in C_LOOKUP
  //--------------------------------------------------
  assign vpn     = addr_q[VADDR_W-1:OFFSET_W];
  assign tlb_idx = vpn[TLB_IDX_W-1:0];
  assign vtag    = vpn[VPN_W-1:TLB_IDX_W];
  assign ppn     = vmem_on ? tlb_ppn[tlb_idx] : tlb_idx;  // identity map when off
  assign fault   = vmem_on && (!tlb_valid[tlb_idx] || (tlb_tag[tlb_idx] != vtag));
  assign paddr   = {ppn, addr_q[OFFSET_W-1:0]};

  assign line_idx = paddr[CACHE_IDX_W-1:0];
  assign line_tag = paddr[PADDR_W-1:CACHE_IDX_W];
  assign hit      = line_valid[line_idx] && (tag_mem[line_idx] == line_tag);

  assign fill_idx  = paddr_q[CACHE_IDX_W-1:0];
  assign fill_tag  = paddr_q[PADDR_W-1:CACHE_IDX_W];
  assign snoop_idx = snoop_addr[CACHE_IDX_W-1:0];
  assign snoop_tag = snoop_addr[PADDR_W-1:CACHE_IDX_W];
  assign fill_done = (state == C_BUS_WAIT) && m0_rsp_valid && (req_op_q == OP_READ);

  // bus request held stable from C_BUS_REQ entry
  assign m0_req_valid = (state == C_BUS_REQ);
  assign m0_req_op    = (req_op_q == OP_WRITE) ? BUS_WRITE : BUS_READ;
  assign m0_req_addr  = paddr_q;
  assign m0_req_wdata = wdata_q;

  //--------------------------------------------------
  // control state and valid bits
  //--------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= C_IDLE;
      tlb_valid  <= '0;
      line_valid <= '0;
    end
    else
    begin
      if (snoop_valid && line_valid[snoop_idx] && (tag_mem[snoop_idx] == snoop_tag))
        line_valid[snoop_idx] <= 1'b0;  // dma wrote over this line
      case (state)
        C_IDLE:
        begin
          if (accept)
            state <= C_LOOKUP;
        end
        C_LOOKUP:
        begin
          if (req_op_q == OP_TLB_WRITE)
          begin
            tlb_valid[tlb_idx] <= 1'b1;
            state              <= C_RESPOND;
          end
          else if (fault || ((req_op_q == OP_READ) && hit))
            state <= C_RESPOND;  // no bus access
          else
            state <= C_BUS_REQ;
        end
        C_BUS_REQ:
        begin
          if (m0_req_ready)
            state <= C_BUS_WAIT;
        end
        C_BUS_WAIT:
        begin
          if (m0_rsp_valid)
            state <= C_RESPOND;
          if (fill_done)
            line_valid[fill_idx] <= 1'b1;  // fill wins over a snoop
        end
        default:
          state <= C_IDLE;  // C_RESPOND
      endcase
    end
  end

  //--------------------------------------------------
  // request, response and array contents
  //--------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_op_q <= cpu_req_op;
      addr_q   <= cpu_addr;
      wdata_q  <= cpu_wdata;
    end
    if (state == C_LOOKUP)
    begin
      paddr_q     <= paddr;
      rsp_fault_q <= fault && (req_op_q != OP_TLB_WRITE);
      if ((req_op_q == OP_READ) && hit && !fault)
        rsp_data_q <= data_mem[line_idx];
      else
        rsp_data_q <= '0;
      if (req_op_q == OP_TLB_WRITE)
      begin
        tlb_tag[tlb_idx] <= wdata_q[TLB_TAG_W-1:0];
        tlb_ppn[tlb_idx] <= wdata_q[TLB_TAG_W+PPN_W-1:TLB_TAG_W];
      end
      if ((req_op_q == OP_WRITE) && hit && !fault)
        data_mem[line_idx] <= wdata_q;  // write-through, no allocate
    end
    if (fill_done)
    begin
      rsp_data_q         <= m0_rsp_rdata;
      data_mem[fill_idx] <= m0_rsp_rdata;
      tag_mem[fill_idx]  <= fill_tag;
    end
  end

endmodule

//--- rtl/dma_copier.sv
`timescale 1ns/100ps

module dma_copier
  import snow_bus_pkg::*;
(
  input  logic                 CPU_CLK,
  input  logic                 RST,
  // command port
  input  logic                 dma_cmd_valid,
  output logic                 dma_cmd_ready,
  input  logic [PADDR_W-1:0]   dma_src,
  input  logic [PADDR_W-1:0]   dma_dst,
  input  logic [DMA_LEN_W-1:0] dma_len,
  output logic                 dma_done,
  // bus master port
  output logic                 m1_req_valid,
  input  logic                 m1_req_ready,
  output bus_op_t              m1_req_op,
  output logic [PADDR_W-1:0]   m1_req_addr,
  output logic [DATA_W-1:0]    m1_req_wdata,
  input  logic                 m1_rsp_valid,
  input  logic [DATA_W-1:0]    m1_rsp_rdata
);

  dma_state_t           state;
  logic [PADDR_W-1:0]   src_q;
  logic [PADDR_W-1:0]   dst_q;
  logic [DMA_LEN_W-1:0] cnt_q;   // words left, zero is 256
  logic [DATA_W-1:0]    buf_q;   // word in flight

  assign dma_cmd_ready = (state == D_IDLE);
  assign m1_req_valid  = (state == D_READ) || (state == D_WRITE);
  assign m1_req_op     = (state == D_WRITE) ? BUS_WRITE : BUS_READ;
  assign m1_req_addr   = (state == D_WRITE) ? dst_q : src_q;
  assign m1_req_wdata  = buf_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state    <= D_IDLE;
      dma_done <= 1'b0;
    end
    else
    begin
      dma_done <= 1'b0;
      case (state)
        D_IDLE:
        begin
          if (dma_cmd_valid)
            state <= D_READ;
        end
        D_READ:
        begin
          if (m1_req_ready)
            state <= D_READ_WAIT;
        end
        D_READ_WAIT:
        begin
          if (m1_rsp_valid)
            state <= D_WRITE;
        end
        D_WRITE:
        begin
          if (m1_req_ready)
            state <= D_WRITE_WAIT;
        end
        default:
        begin
          if (m1_rsp_valid)
          begin
            if (cnt_q == DMA_LEN_W'(1))
            begin
              state    <= D_IDLE;
              dma_done <= 1'b1;  // last write acked
            end
            else
              state <= D_READ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (dma_cmd_valid && dma_cmd_ready)
    begin
      src_q <= dma_src;
      dst_q <= dma_dst;
      cnt_q <= dma_len;
    end
    else if ((state == D_WRITE_WAIT) && m1_rsp_valid)
    begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
    if ((state == D_READ_WAIT) && m1_rsp_valid)
      buf_q <= m1_rsp_rdata;
  end

endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter
  import snow_bus_pkg::*;
(
  input  logic               CPU_CLK,
  input  logic               RST,
  // master 0, cache
  input  logic               m0_req_valid,
  output logic               m0_req_ready,
  input  bus_op_t            m0_req_op,
  input  logic [PADDR_W-1:0] m0_req_addr,
  input  logic [DATA_W-1:0]  m0_req_wdata,
  output logic               m0_rsp_valid,
  output logic [DATA_W-1:0]  m0_rsp_rdata,
  // master 1, dma
  input  logic               m1_req_valid,
  output logic               m1_req_ready,
  input  bus_op_t            m1_req_op,
  input  logic [PADDR_W-1:0] m1_req_addr,
  input  logic [DATA_W-1:0]  m1_req_wdata,
  output logic               m1_rsp_valid,
  output logic [DATA_W-1:0]  m1_rsp_rdata,
  // memory side
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  output bus_op_t            mem_req_op,
  output logic [PADDR_W-1:0] mem_req_addr,
  output logic [DATA_W-1:0]  mem_req_wdata,
  input  logic               mem_rsp_valid,
  input  logic [DATA_W-1:0]  mem_rsp_rdata,
  // dma write snoop
  output logic               snoop_valid,
  output logic [PADDR_W-1:0] snoop_addr
);

  logic locked_q;  // one transaction outstanding
  logic owner_q;   // 1 when m1 owns the bus
  logic last_q;    // last master served
  logic pick;
  logic accept;

  // on contention the master not served last wins
  assign pick = (m0_req_valid && m1_req_valid) ? !last_q : m1_req_valid;

  assign mem_req_valid = !locked_q && (pick ? m1_req_valid : m0_req_valid);
  assign mem_req_op    = pick ? m1_req_op : m0_req_op;
  assign mem_req_addr  = pick ? m1_req_addr : m0_req_addr;
  assign mem_req_wdata = pick ? m1_req_wdata : m0_req_wdata;
  assign m0_req_ready  = !locked_q && !pick && mem_req_ready;
  assign m1_req_ready  = !locked_q && pick && mem_req_ready;
  assign accept        = mem_req_valid && mem_req_ready;

  assign m0_rsp_valid = mem_rsp_valid && !owner_q;
  assign m1_rsp_valid = mem_rsp_valid && owner_q;
  assign m0_rsp_rdata = mem_rsp_rdata;
  assign m1_rsp_rdata = mem_rsp_rdata;

  assign snoop_valid = accept && pick && (m1_req_op == BUS_WRITE);
  assign snoop_addr  = m1_req_addr;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
      last_q   <= 1'b0;
    end
    else if (accept)
    begin
      locked_q <= 1'b1;
      owner_q  <= pick;
      last_q   <= pick;
    end
    else if (mem_rsp_valid)
      locked_q <= 1'b0;  // grant released with the response
  end

endmodule

//--- rtl/snow_memory.sv
`timescale 1ns/100ps

module snow_memory
  import snow_bus_pkg::*;
(
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               mem_req_valid,
  output logic               mem_req_ready,
  input  bus_op_t            mem_req_op,
  input  logic [PADDR_W-1:0] mem_req_addr,
  input  logic [DATA_W-1:0]  mem_req_wdata,
  output logic               mem_rsp_valid,
  output logic [DATA_W-1:0]  mem_rsp_rdata
);

  logic [DATA_W-1:0]    mem [MEM_WORDS];
  logic [LAT_CNT_W-1:0] lat_cnt;    // cycles to response
  logic                 clearing;   // zero-fill walk after reset
  logic [PADDR_W-1:0]   clr_addr;
  logic [DATA_W-1:0]    rdata_q;
  logic                 accept;

  assign mem_req_ready = !clearing && (lat_cnt == '0);
  assign accept        = mem_req_valid && mem_req_ready;
  assign mem_rsp_valid = (lat_cnt == LAT_CNT_W'(1));
  assign mem_rsp_rdata = rdata_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      lat_cnt  <= '0;
      clearing <= 1'b1;
      clr_addr <= '0;
    end
    else
    begin
      if (accept)
        lat_cnt <= LAT_CNT_W'(MEM_LATENCY);
      else if (lat_cnt != '0)
        lat_cnt <= lat_cnt - 1'b1;
      if (clearing)
      begin
        clr_addr <= clr_addr + 1'b1;
        if (clr_addr == PADDR_W'(MEM_WORDS - 1))
          clearing <= 1'b0;
      end
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (clearing)
      mem[clr_addr] <= '0;
    else if (accept && (mem_req_op == BUS_WRITE))
      mem[mem_req_addr] <= mem_req_wdata;  // write lands on acceptance
    if (accept)
      rdata_q <= mem[mem_req_addr];
  end

endmodule

//--- rtl/snowball_top.sv
`timescale 1ns/100ps

module snowball_top
  import snow_cache_pkg::*;
  import snow_bus_pkg::*;
(
  input  logic                 CPU_CLK,
  input  logic                 RST,
  input  logic                 vmem_on,
  input  logic                 cpu_req_valid,
  input  cpu_op_t              cpu_req_op,
  input  logic [VADDR_W-1:0]   cpu_addr,
  input  logic [DATA_W-1:0]    cpu_wdata,
  output logic                 cpu_req_ready,
  output logic                 cpu_rsp_valid,
  output logic [DATA_W-1:0]    cpu_rsp_data,
  output logic                 cpu_rsp_fault,
  input  logic                 dma_cmd_valid,
  input  logic [PADDR_W-1:0]   dma_src,
  input  logic [PADDR_W-1:0]   dma_dst,
  input  logic [DMA_LEN_W-1:0] dma_len,
  output logic                 dma_cmd_ready,
  output logic                 dma_done
);

  //--------------------------------------------------
  // master buses and memory side
  //--------------------------------------------------
  logic               m0_req_valid, m0_req_ready, m0_rsp_valid;
  bus_op_t            m0_req_op;
  logic [PADDR_W-1:0] m0_req_addr;
  logic [DATA_W-1:0]  m0_req_wdata, m0_rsp_rdata;

  logic               m1_req_valid, m1_req_ready, m1_rsp_valid;
  bus_op_t            m1_req_op;
  logic [PADDR_W-1:0] m1_req_addr;
  logic [DATA_W-1:0]  m1_req_wdata, m1_rsp_rdata;

  logic               mem_req_valid, mem_req_ready, mem_rsp_valid;
  bus_op_t            mem_req_op;
  logic [PADDR_W-1:0] mem_req_addr;
  logic [DATA_W-1:0]  mem_req_wdata, mem_rsp_rdata;

  logic               snoop_valid;
  logic [PADDR_W-1:0] snoop_addr;

  snowball_cache u_cache (
    .CPU_CLK, .RST, .vmem_on,
    .cpu_req_valid, .cpu_req_ready, .cpu_req_op, .cpu_addr, .cpu_wdata,
    .cpu_rsp_valid, .cpu_rsp_data, .cpu_rsp_fault,
    .m0_req_valid, .m0_req_ready, .m0_req_op, .m0_req_addr, .m0_req_wdata,
    .m0_rsp_valid, .m0_rsp_rdata,
    .snoop_valid, .snoop_addr
  );

  dma_copier u_dma (
    .CPU_CLK, .RST,
    .dma_cmd_valid, .dma_cmd_ready, .dma_src, .dma_dst, .dma_len, .dma_done,
    .m1_req_valid, .m1_req_ready, .m1_req_op, .m1_req_addr, .m1_req_wdata,
    .m1_rsp_valid, .m1_rsp_rdata
  );

  bus_arbiter u_arb (
    .CPU_CLK, .RST,
    .m0_req_valid, .m0_req_ready, .m0_req_op, .m0_req_addr, .m0_req_wdata,
    .m0_rsp_valid, .m0_rsp_rdata,
    .m1_req_valid, .m1_req_ready, .m1_req_op, .m1_req_addr, .m1_req_wdata,
    .m1_rsp_valid, .m1_rsp_rdata,
    .mem_req_valid, .mem_req_ready, .mem_req_op, .mem_req_addr, .mem_req_wdata,
    .mem_rsp_valid, .mem_rsp_rdata,
    .snoop_valid, .snoop_addr
  );

  snow_memory u_mem (
    .CPU_CLK, .RST,
    .mem_req_valid, .mem_req_ready, .mem_req_op, .mem_req_addr, .mem_req_wdata,
    .mem_rsp_valid, .mem_rsp_rdata
  );

endmodule

//--- tests/snowball_props.sv
`timescale 1ns/100ps

module snowball_props
  import snow_bus_pkg::*;
(
  input logic               CPU_CLK,
  input logic               RST,
  input logic               m0_req_valid,
  input logic               m0_req_ready,
  input bus_op_t            m0_req_op,
  input logic [PADDR_W-1:0] m0_req_addr,
  input logic               m1_req_valid,
  input logic               m1_req_ready,
  input bus_op_t            m1_req_op,
  input logic [PADDR_W-1:0] m1_req_addr,
  input logic               mem_rsp_valid,
  input logic               locked_q,
  input logic               snoop_valid
);

  int n_failed = 0;  // failure count for the testbench summary

  a_m0_hold : assert property (@(posedge CPU_CLK) disable iff (!RST)
    m0_req_valid && !m0_req_ready |=>
      m0_req_valid && $stable(m0_req_op) && $stable(m0_req_addr))
  else
  begin
    n_failed++;
    $error("cache bus request changed while stalled");
  end

  a_m1_hold : assert property (@(posedge CPU_CLK) disable iff (!RST)
    m1_req_valid && !m1_req_ready |=>
      m1_req_valid && $stable(m1_req_op) && $stable(m1_req_addr))
  else
  begin
    n_failed++;
    $error("dma bus request changed while stalled");
  end

  // response only while a transaction is open
  a_rsp_owned : assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_rsp_valid |-> locked_q)
  else
  begin
    n_failed++;
    $error("memory response with no request outstanding");
  end

  a_snoop : assert property (@(posedge CPU_CLK) disable iff (!RST)
    snoop_valid |-> m1_req_valid && m1_req_ready && (m1_req_op == BUS_WRITE))
  else
  begin
    n_failed++;
    $error("snoop pulse without an accepted dma write");
  end

endmodule

bind bus_arbiter snowball_props u_props (.*);

//--- tests/snowball_tb.sv
`timescale 1ns/100ps

module snowball_tb
  import snow_cache_pkg::*;
  import snow_bus_pkg::*;
();

  localparam int TIMEOUT = 20000;  // long enough for the memory clear walk

  logic                 CPU_CLK;
  logic                 RST;
  logic                 vmem_on;
  logic                 cpu_req_valid;
  cpu_op_t              cpu_req_op;
  logic [VADDR_W-1:0]   cpu_addr;
  logic [DATA_W-1:0]    cpu_wdata;
  logic                 cpu_req_ready;
  logic                 cpu_rsp_valid;
  logic [DATA_W-1:0]    cpu_rsp_data;
  logic                 cpu_rsp_fault;
  logic                 dma_cmd_valid;
  logic [PADDR_W-1:0]   dma_src;
  logic [PADDR_W-1:0]   dma_dst;
  logic [DMA_LEN_W-1:0] dma_len;
  logic                 dma_cmd_ready;
  logic                 dma_done;

  // reference model
  logic [DATA_W-1:0]    mem_model [MEM_WORDS];
  logic [TLB_TAG_W-1:0] tlb_tag_m [TLB_ENTRIES];
  logic [PPN_W-1:0]     tlb_ppn_m [TLB_ENTRIES];
  logic                 tlb_valid_m [TLB_ENTRIES];

  integer seed = 8;
  int     n_checks = 0;
  int     err_data = 0;
  int     err_fault = 0;
  int     err_busy = 0;
  int     err_other = 0;
  int     n_accepted = 0;
  int     n_responses = 0;

  snowball_top u_snowball_top (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #4 CPU_CLK = ~CPU_CLK;
  end

  // accepted requests and responses
  always @(posedge CPU_CLK)
  begin
    if (RST && cpu_req_valid && cpu_req_ready)
      n_accepted++;
    if (RST && cpu_rsp_valid)
      n_responses++;
  end

  //--------------------------------------------------
  // compare tasks
  //--------------------------------------------------
  task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
    n_checks++;
    if (actual !== expected)
    begin
      err_data++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_fault(input string name, input logic actual, input logic expected);
    n_checks++;
    if (actual !== expected)
    begin
      err_fault++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_busy(input string name, input logic actual, input logic expected);
    n_checks++;
    if (actual !== expected)
    begin
      err_busy++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic end_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  //--------------------------------------------------
  // model helpers
  //--------------------------------------------------
  function automatic void translate(input logic [VADDR_W-1:0] va,
                                    output logic [PADDR_W-1:0] pa, output logic flt);
    logic [TLB_IDX_W-1:0] idx;
    idx = va[OFFSET_W+TLB_IDX_W-1:OFFSET_W];
    flt = vmem_on && !(tlb_valid_m[idx] && (tlb_tag_m[idx] == va[VADDR_W-1:OFFSET_W+TLB_IDX_W]));
    pa  = {(vmem_on ? tlb_ppn_m[idx] : idx), va[OFFSET_W-1:0]};
  endfunction

  function automatic logic [VADDR_W-1:0] vaddr_for(input logic [PADDR_W-1:0] pa);
    logic [VADDR_W-1:0] va;
    va              = $random(seed);  // upper bits unused without translation
    va[PADDR_W-1:0] = pa;
    return va;
  endfunction

  task automatic cpu_access(input cpu_op_t op, input logic [VADDR_W-1:0] va,
                            input logic [DATA_W-1:0] wd, input bit expect_hit);
    logic [PADDR_W-1:0]   pa;
    logic                 flt;
    logic [TLB_IDX_W-1:0] idx;
    int                   cycles;
    translate(va, pa, flt);
    idx = va[OFFSET_W+TLB_IDX_W-1:OFFSET_W];
    @(negedge CPU_CLK);
    cpu_req_valid = 1'b1;
    cpu_req_op    = op;
    cpu_addr      = va;
    cpu_wdata     = wd;
    cycles        = 0;
    while (!cpu_req_ready)
    begin
      @(negedge CPU_CLK);
      cycles++;
      if (cycles > TIMEOUT)
        end_on_timeout("cpu_req_ready stayed low");
    end
    @(negedge CPU_CLK);  // taken on the rising edge before
    cpu_req_valid = 1'b0;
    cycles        = 1;
    while (!cpu_rsp_valid)
    begin
      check_busy("cpu_req_ready", cpu_req_ready, 1'b0);
      @(negedge CPU_CLK);
      cycles++;
      if (cycles > TIMEOUT)
        end_on_timeout("no response to a cpu request");
    end
    check_busy("cpu_req_ready", cpu_req_ready, 1'b0);
    check_fault("cpu_rsp_fault", cpu_rsp_fault, flt && (op != OP_TLB_WRITE));
    if (op == OP_READ)
      check_data("cpu_rsp_data", cpu_rsp_data, flt ? '0 : mem_model[pa]);
    if ((expect_hit || flt || (op == OP_TLB_WRITE)) && (cycles != 2))
    begin
      err_other++;
      $display("Error at %0t ns: response latency is %0d, expected 2", $time, cycles);
    end
    if ((op == OP_WRITE) && !flt)
      mem_model[pa] = wd;
    if (op == OP_TLB_WRITE)
    begin
      tlb_tag_m[idx]   = wd[TLB_TAG_W-1:0];
      tlb_ppn_m[idx]   = wd[TLB_TAG_W+PPN_W-1:TLB_TAG_W];
      tlb_valid_m[idx] = 1'b1;
    end
    @(negedge CPU_CLK);
    check_busy("cpu_rsp_valid", cpu_rsp_valid, 1'b0);  // one pulse only
    check_busy("cpu_req_ready", cpu_req_ready, 1'b1);
  endtask

  task automatic run_dma(input logic [PADDR_W-1:0] src, input logic [PADDR_W-1:0] dst,
                         input logic [DMA_LEN_W-1:0] len);
    int cycles;
    int n_words;
    n_words = (len == 0) ? 256 : len;
    @(negedge CPU_CLK);
    cycles = 0;
    while (!dma_cmd_ready)
    begin
      @(negedge CPU_CLK);
      cycles++;
      if (cycles > TIMEOUT)
        end_on_timeout("dma_cmd_ready stayed low");
    end
    dma_cmd_valid = 1'b1;
    dma_src       = src;
    dma_dst       = dst;
    dma_len       = len;
    @(negedge CPU_CLK);
    dma_cmd_valid = 1'b0;
    cycles        = 0;
    while (!dma_done)
    begin
      check_busy("dma_cmd_ready", dma_cmd_ready, 1'b0);
      @(negedge CPU_CLK);
      cycles++;
      if (cycles > TIMEOUT)
        end_on_timeout("dma_done never pulsed");
    end
    for (int i = 0; i < n_words; i++)
      mem_model[dst + i] = mem_model[src + i];
    @(negedge CPU_CLK);
    check_busy("dma_cmd_ready", dma_cmd_ready, 1'b1);
  endtask

  task automatic cpu_traffic(input int n);
    logic [PADDR_W-1:0] pa;
    for (int k = 0; k < n; k++)
    begin
      pa = 14'h2000 | PADDR_W'($random(seed));  // clear of both dma ranges
      cpu_access(OP_WRITE, vaddr_for(pa), $random(seed), 1'b0);
      cpu_access(OP_READ, vaddr_for(pa), '0, 1'b0);
    end
  endtask

  task automatic copy_test(input bit prime_dst, input int n_traffic);
    logic [PADDR_W-1:0]   src;
    logic [PADDR_W-1:0]   dst;
    logic [DMA_LEN_W-1:0] len;
    int                   n_words;
    src     = $random(seed) & 14'h0eff;
    dst     = 14'h1000 | ($random(seed) & 14'h0eff);
    len     = $random(seed);
    n_words = (len == 0) ? 256 : len;
    for (int i = 0; i < n_words; i++)
      cpu_access(OP_WRITE, vaddr_for(PADDR_W'(src + i)), $random(seed), 1'b0);
    for (int i = 0; prime_dst && (i < n_words); i++)
    begin
      cpu_access(OP_WRITE, vaddr_for(PADDR_W'(dst + i)), $random(seed), 1'b0);
      cpu_access(OP_READ, vaddr_for(PADDR_W'(dst + i)), '0, 1'b0);  // line now cached
    end
    fork
      run_dma(src, dst, len);
      cpu_traffic(n_traffic);
    join
    for (int i = 0; i < n_words; i++)
      cpu_access(OP_READ, vaddr_for(PADDR_W'(dst + i)), '0, 1'b0);
  endtask

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------
  initial
  begin
    logic [VADDR_W-1:0]   va;
    logic [TLB_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    wd;
    logic [PADDR_W-1:0]   faulted [$];
    int                   err_assert;
    RST           = 1'b0;
    vmem_on       = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req_op    = OP_READ;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    dma_cmd_valid = 1'b0;
    dma_src       = '0;
    dma_dst       = '0;
    dma_len       = '0;
    for (int a = 0; a < MEM_WORDS; a++)
      mem_model[a] = '0;
    for (int t = 0; t < TLB_ENTRIES; t++)
    begin
      tlb_tag_m[t]   = '0;
      tlb_ppn_m[t]   = '0;
      tlb_valid_m[t] = 1'b0;
    end
    repeat (10) @(negedge CPU_CLK);
    RST = 1'b1;
    @(negedge CPU_CLK);
    check_busy("cpu_req_ready", cpu_req_ready, 1'b1);
    check_busy("dma_cmd_ready", dma_cmd_ready, 1'b1);

    repeat (24)
    begin
      va = $random(seed);
      wd = $random(seed);
      cpu_access(OP_WRITE, va, wd, 1'b0);
      cpu_access(OP_READ, va, '0, 1'b0);
      cpu_access(OP_READ, va, '0, 1'b1);   // filled by the read before
      cpu_access(OP_WRITE, va, ~wd, 1'b0);
      cpu_access(OP_READ, va, '0, 1'b1);   // write-through keeps the line
      cpu_access(OP_READ, $random(seed), '0, 1'b0);
    end

    repeat (10)
    begin
      idx = $random(seed);
      cpu_access(OP_TLB_WRITE, {10'h0, idx, 10'h0}, $random(seed), 1'b0);
    end
    @(negedge CPU_CLK);
    vmem_on = 1'b1;
    repeat (32)
    begin
      idx = $random(seed);
      va  = $random(seed);
      va[VADDR_W-1:OFFSET_W] = {tlb_tag_m[idx], idx};  // unwritten entries fault
      cpu_access(OP_WRITE, va, $random(seed), 1'b0);
      cpu_access(OP_READ, va, '0, 1'b0);
      va[VADDR_W-1:OFFSET_W+TLB_IDX_W] = ~tlb_tag_m[idx];  // wrong tag
      cpu_access(OP_READ, va, '0, 1'b0);
      cpu_access(OP_WRITE, va, $random(seed), 1'b0);
      faulted.push_back({tlb_ppn_m[idx], va[OFFSET_W-1:0]});  // where a leaked write lands
    end
    @(negedge CPU_CLK);
    vmem_on = 1'b0;
    foreach (faulted[f])
      cpu_access(OP_READ, vaddr_for(faulted[f]), '0, 1'b0);  // faulting writes left memory alone

    copy_test(1'b0, 0);
    copy_test(1'b1, 0);   // stale lines must be snooped out
    copy_test(1'b0, 12);  // cpu competes for the bus

    if (n_accepted != n_responses)
    begin
      err_other++;
      $display("Error at %0t ns: %0d requests accepted but %0d responses seen",
               $time, n_accepted, n_responses);
    end
    err_assert = u_snowball_top.u_arb.u_props.n_failed;
    $display("checks %0d, errors: data %0d, fault %0d, handshake %0d, other %0d, assertion %0d",
             n_checks, err_data, err_fault, err_busy, err_other, err_assert);
    if ((err_data + err_fault + err_busy + err_other + err_assert) == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- verilog.f
rtl/snow_cache_pkg.sv
rtl/snow_bus_pkg.sv
rtl/snowball_cache.sv
rtl/dma_copier.sv
rtl/bus_arbiter.sv
rtl/snow_memory.sv
rtl/snowball_top.sv
tests/snowball_props.sv
tests/snowball_tb.sv

//--- Bender.yml
package:
  name: snowball

sources:
  - rtl/snow_cache_pkg.sv
  - rtl/snow_bus_pkg.sv
  - rtl/snowball_cache.sv
  - rtl/dma_copier.sv
  - rtl/bus_arbiter.sv
  - rtl/snow_memory.sv
  - rtl/snowball_top.sv
  - target: test
    files:
      - tests/snowball_props.sv
      - tests/snowball_tb.sv
